/* hex_loader.f */
verilog/hex_loader_pkg.sv
verilog/uart_receiver.sv
verilog/hex_parser.sv
verilog/word_monitor.sv
verilog/seven_segment_display.sv
verilog/hex_loader_top.sv
testbench/hex_loader_props.sv
testbench/tb_hex_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the hex loader testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_hex_loader \
    --Mdir obj_dir \
    -f hex_loader.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build returned status $status"
    exit "$status"
fi

./obj_dir/Vtb_hex_loader
status=$?
if [ "$status" -ne 0 ]; then
    echo "testbench run returned status $status"
    exit "$status"
fi

exit 0

/* testbench/hex_loader_props.sv */
`timescale 1ns/100ps

module hex_loader_props
#(
    parameter w_digit = 4
)
(
    input                 clk,
    input                 rst,
    input                 write_valid,
    input                 error,
    input [w_digit - 1:0] digit
);

    // write strobe lasts a single cycle
    write_single_cycle: assert property (@(posedge clk) disable iff (rst)
        write_valid |=> !write_valid)
        else $error("write strobe stayed high for more than one cycle");

    write_without_error: assert property (@(posedge clk) disable iff (rst)
        !(write_valid && error))
        else $error("write strobe and error flag high in the same cycle");

    // exactly one digit lit except in the first cycle after reset
    digit_one_cold: assert property (@(posedge clk) disable iff (rst)
        $past(rst) || $onehot(~digit))
        else $error("display digit select is not one-cold");

endmodule

bind hex_parser hex_loader_props #(.w_digit(1)) parser_props_i
(
    .clk         (clk),
    .rst         (rst),
    .write_valid (write.valid),
    .error       (error),
    .digit       (1'b0)
);

bind seven_segment_display hex_loader_props #(.w_digit(w_digit)) display_props_i
(
    .clk         (clk),
    .rst         (rst),
    .write_valid (1'b0),
    .error       (1'b0),
    .digit       (digit)
);

/* testbench/tb_hex_loader.sv */
`timescale 1ns/100ps

module tb_hex_loader;

    localparam clks_per_bit   = 8;
    localparam timeout_cycles = 2000;
    localparam w_digit        = 4;
    localparam refresh_cycles = 4;
    localparam scan_limit     = 4 * w_digit * refresh_cycles;

    logic                       clk;
    logic                       rst;
    logic                       uart_rx;
    logic [3:0]                 key;
    hex_loader_pkg::hex_write_t write;
    logic [3:0]                 led;
    logic [7:0]                 abcdefgh;
    logic [w_digit - 1:0]       digit;

    hex_loader_pkg::hex_write_t write_log [$];
    hex_loader_pkg::word_t      sent_bytes;
    hex_loader_pkg::word_t      exp_address;
    hex_loader_pkg::word_t      exp_data;
    hex_loader_pkg::word_t      stray_address;
    int                         writes_before;
    logic [3:0]                 led_before;

    hex_loader_top
    #(
        .clks_per_bit   (clks_per_bit),
        .timeout_cycles (timeout_cycles),
        .w_digit        (w_digit),
        .refresh_cycles (refresh_cycles)
    )
    hex_loader_top_i
    (
        .clk      (clk),
        .rst      (rst),
        .uart_rx  (uart_rx),
        .key      (key),
        .write    (write),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // writes are collected at the falling edge
    // terminator byte arrived one cycle before the write strobe
    always @(negedge clk)
    begin
        if (write.valid)
        begin
            write_log.push_back(write);
            check_value("write strobe led", 32'h0, {31'h0, led[2]});
            check_value("terminator byte led", 32'h0, {31'h0, led_before[3]});
        end
        led_before = led;
    end

    //----------------------------------------------------------------------
    // failure reporting and checks
    //----------------------------------------------------------------------

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        stop_with_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    //----------------------------------------------------------------------
    // serial stimulus
    //----------------------------------------------------------------------

    // 8N1 frame, LSB first
    task automatic send_char(input logic [7:0] ch);
        logic [9:0] frame;
        frame = {1'b1, ch, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (clks_per_bit - 1) @(posedge clk);
        end
        sent_bytes = {sent_bytes[23:0], ch};
    endtask

    task automatic send_text(input string text);
        for (int i = 0; i < text.len(); i++)
            send_char(8'(text[i]));
    endtask

    // odd digits in upper case when mixed
    function automatic string hex_text(input hex_loader_pkg::word_t value, input int digits,
                                       input bit mixed_case);
        string      text;
        logic [3:0] nib;
        logic [7:0] ch;
        text = "";
        for (int i = digits - 1; i >= 0; i--)
        begin
            nib = value[i * 4 +: 4];
            if (nib < 4'd10)
                ch = 8'h30 + {4'h0, nib};
            else if (mixed_case && (i % 2 == 1))
                ch = 8'h37 + {4'h0, nib};
            else
                ch = 8'h57 + {4'h0, nib};
            text = $sformatf("%s%c", text, ch);
        end
        return text;
    endfunction

    //----------------------------------------------------------------------
    // waits and display decoding
    //----------------------------------------------------------------------

    task automatic wait_for_write(input int count);
        int cycles;
        cycles = 0;
        while (write_log.size() < count)
        begin
            if (cycles == 200)
                report_timeout("a write strobe");
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_for_led(input int index, input logic value, input int limit,
                                input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (led[index] !== value)
        begin
            if (cycles == limit)
                report_timeout(what);
            @(negedge clk);
            cycles++;
        end
    endtask

    // active high abcdefg, dot in bit 0
    function automatic logic [7:0] segments_of(input logic [3:0] value);
        string      lit;
        logic [7:0] pattern;
        int         k;
        case (value)
        4'h0: lit = "abcdef";
        4'h1: lit = "bc";
        4'h2: lit = "abdeg";
        4'h3: lit = "abcdg";
        4'h4: lit = "bcfg";
        4'h5: lit = "acdfg";
        4'h6: lit = "acdefg";
        4'h7: lit = "abc";
        4'h8: lit = "abcdefg";
        4'h9: lit = "abcdfg";
        4'ha: lit = "abcefg";
        4'hb: lit = "cdefg";
        4'hc: lit = "adef";
        4'hd: lit = "bcdeg";
        4'he: lit = "adefg";
        default: lit = "aefg";
        endcase
        pattern = '0;
        for (int i = 0; i < lit.len(); i++)
        begin
            k = 7 - (int'(lit[i]) - 97);
            pattern[k] = 1'b1;
        end
        return pattern;
    endfunction

    task automatic check_display(input string name, input logic [3:0] key_code,
                                 input logic [15:0] value);
        logic [w_digit - 1:0] select;
        int                   cycles;
        @(posedge clk);
        key <= key_code;
        repeat (3) @(posedge clk);
        for (int pos = 0; pos < w_digit; pos++)
        begin
            select = ~(w_digit'(1) << pos);
            cycles = 0;
            @(negedge clk);
            while (digit !== select)
            begin
                if (cycles == scan_limit)
                    report_timeout($sformatf("display digit %0d", pos));
                @(negedge clk);
                cycles++;
            end
            check_value($sformatf("%s digit %0d", name, pos),
                        {24'h0, ~segments_of(value[pos * 4 +: 4])}, {24'h0, abcdefgh});
        end
    endtask

    //----------------------------------------------------------------------
    // test sequence
    //----------------------------------------------------------------------

    initial
    begin
        rst        = 1'b1;
        uart_rx    = 1'b1;
        key        = 4'b1111;
        sent_bytes = '0;
        void'($urandom(32'hba70_f30b));
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        // idle after reset
        @(negedge clk);
        check_value("reset leds", 32'hf, {28'h0, led});
        check_display("reset bytes low", 4'b1111, 16'h0000);
        check_value("reset writes", 32'd0, write_log.size());

        // full record in mixed case
        exp_address = $urandom();
        exp_data    = $urandom();
        send_text({hex_text(exp_address, 8, 1'b1), " ", hex_text(exp_data, 8, 1'b1)});
        send_char(8'h0d);
        wait_for_write(1);
        check_value("full record address", exp_address, write_log[0].address);
        check_value("full record data", exp_data, write_log[0].data);
        @(negedge clk);
        check_value("full record error led", 32'h1, {31'h0, led[0]});

        // short fields, several spaces
        exp_address = $urandom() & 32'h0000_0fff;
        exp_data    = $urandom() & 32'h000f_ffff;
        send_text({hex_text(exp_address, 3, 1'b0), "   ", hex_text(exp_data, 5, 1'b1)});
        send_char(8'h0a);
        wait_for_write(2);
        check_value("short record address", exp_address, write_log[1].address);
        check_value("short record data", exp_data, write_log[1].data);

        // bad character, then a clean record
        writes_before = write_log.size();
        send_text("12x4 55");
        send_char(8'h0d);
        wait_for_led(0, 1'b0, 20, "error led after bad character");
        repeat (20) @(negedge clk);
        check_value("bad record writes", writes_before, write_log.size());
        exp_address = $urandom();
        exp_data    = $urandom();
        send_text({hex_text(exp_address, 8, 1'b0), " ", hex_text(exp_data, 8, 1'b0)});
        send_char(8'h0a);
        wait_for_write(writes_before + 1);
        check_value("recovery address", exp_address, write_log[writes_before].address);
        check_value("recovery data", exp_data, write_log[writes_before].data);
        @(negedge clk);
        check_value("recovery error led", 32'h1, {31'h0, led[0]});

        // record that stalls after its address
        writes_before = write_log.size();
        stray_address = $urandom() & 32'h00ff_ffff;
        send_text(hex_text(stray_address, 6, 1'b0));
        @(negedge clk);
        check_value("stalled record busy led", 32'h0, {31'h0, led[1]});
        wait_for_led(0, 1'b0, timeout_cycles + 100, "error led after timeout");
        @(negedge clk);
        check_value("timeout busy led", 32'h1, {31'h0, led[1]});
        check_value("timeout writes", writes_before, write_log.size());

        // key selected slices
        check_display("bytes high", 4'b0111, sent_bytes[31:16]);
        check_display("word high", 4'b1011, exp_data[31:16]);
        check_display("word low", 4'b1101, exp_data[15:0]);
        check_display("address low", 4'b1110, exp_address[15:0]);
        check_display("bytes low", 4'b1111, sent_bytes[15:0]);

        $display("sim passed");
        $finish;
    end

endmodule

/* verilog/hex_loader_pkg.sv */
package hex_loader_pkg;

    //----------------------------------------------------------------------
    // vector types with a meaning
    //----------------------------------------------------------------------

    // one character off the serial line
    typedef logic [7:0]  byte_t;

    // address or data value of a record
    typedef logic [31:0] word_t;

    //----------------------------------------------------------------------
    // parser output and state
    //----------------------------------------------------------------------

    // one parsed write, valid is a single-cycle strobe
    typedef struct packed {
        logic  valid;
        word_t address;
        word_t data;
    } hex_write_t;

    typedef enum logic [2:0] {
        parser_idle,
        parser_address,
        parser_gap,
        parser_data,
        parser_skip
    } parser_state_t;

endpackage

/* verilog/hex_loader_top.sv */
`timescale 1ns/100ps

module hex_loader_top
#(
    // board defaults for a 50 MHz clock and 115200 baud
    parameter clks_per_bit   = 434,
    parameter timeout_cycles = 50_000_000,
    parameter w_digit        = 4,
    parameter refresh_cycles = 31_250
)
(
    input                              clk,
    input                              rst,
    input                              uart_rx,
    input        [3:0]                 key,
    output hex_loader_pkg::hex_write_t write,
    output logic [3:0]                 led,
    output logic [7:0]                 abcdefgh,
    output logic [w_digit - 1:0]       digit
);

    logic                     byte_valid;
    hex_loader_pkg::byte_t    byte_data;
    logic                     busy;
    logic                     error;
    logic [w_digit * 4 - 1:0] number;

    //----------------------------------------------------------------------
    // serial in, records out
    //----------------------------------------------------------------------

    uart_receiver #(.clks_per_bit(clks_per_bit)) uart_receiver_i
    (
        .clk        (clk),
        .rst        (rst),
        .rx         (uart_rx),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    hex_parser #(.timeout_cycles(timeout_cycles)) hex_parser_i
    (
        .clk      (clk),
        .rst      (rst),
        .in_valid (byte_valid),
        .in_char  (byte_data),
        .write    (write),
        .busy     (busy),
        .error    (error)
    );

    //----------------------------------------------------------------------
    // status display
    //----------------------------------------------------------------------

    word_monitor #(.w_digit(w_digit)) word_monitor_i
    (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .write      (write),
        .key        (key),
        .number     (number)
    );

    seven_segment_display
    #(
        .w_digit        (w_digit),
        .refresh_cycles (refresh_cycles)
    )
    seven_segment_display_i
    (
        .clk      (clk),
        .rst      (rst),
        .number   (number),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // leds are active low
    assign led = ~{byte_valid, write.valid, busy, error};

endmodule

/* verilog/hex_parser.sv */
`timescale 1ns/100ps

module hex_parser
#(
    parameter timeout_cycles = 2000
)
(
    input                              clk,
    input                              rst,
    input                              in_valid,
    input  hex_loader_pkg::byte_t      in_char,
    output hex_loader_pkg::hex_write_t write,
    output logic                       busy,
    output logic                       error
);

    localparam w_timer = $clog2(timeout_cycles + 1);

    hex_loader_pkg::parser_state_t state;
    hex_loader_pkg::word_t         address;
    hex_loader_pkg::word_t         data;
    logic                          write_valid;
    logic [w_timer - 1:0]          idle_timer;

    logic                          is_hex;
    logic                          is_space;
    logic                          is_term;
    logic [3:0]                    nibble;

    //----------------------------------------------------------------------
    // character classes
    //----------------------------------------------------------------------

    always_comb
    begin
        is_hex = 1'b1;
        nibble = in_char[3:0];
        if (in_char >= "0" && in_char <= "9")
            nibble = in_char[3:0];
        // letters in either case have 1..6 in the low nibble
        else if ((in_char >= "a" && in_char <= "f") || (in_char >= "A" && in_char <= "F"))
            nibble = in_char[3:0] + 4'd9;
        else
            is_hex = 1'b0;
    end

    assign is_space = (in_char == 8'h20);
    assign is_term  = (in_char == 8'h0d) || (in_char == 8'h0a);

    //----------------------------------------------------------------------
    // record FSM, error and inactivity timeout
    //----------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            state       <= hex_loader_pkg::parser_idle;
            write_valid <= 1'b0;
            error       <= 1'b0;
            idle_timer  <= '0;
        end
        else
        begin
            write_valid <= 1'b0;
            if (in_valid)
            begin
                idle_timer <= '0;
                case (state)
                hex_loader_pkg::parser_idle:
                    // stray terminators between records are fine
                    if (!is_term)
                    begin
                        error <= !is_hex;
                        state <= is_hex ? hex_loader_pkg::parser_address
                                        : hex_loader_pkg::parser_skip;
                    end
                hex_loader_pkg::parser_address,
                hex_loader_pkg::parser_gap:
                    if (is_space)
                        state <= hex_loader_pkg::parser_gap;
                    else if (is_hex)
                    begin
                        if (state == hex_loader_pkg::parser_gap)
                            state <= hex_loader_pkg::parser_data;
                    end
                    else
                    begin
                        // terminator before data also ends the record
                        error <= 1'b1;
                        state <= is_term ? hex_loader_pkg::parser_idle
                                         : hex_loader_pkg::parser_skip;
                    end
                hex_loader_pkg::parser_data:
                    if (is_term)
                    begin
                        write_valid <= 1'b1;
                        state       <= hex_loader_pkg::parser_idle;
                    end
                    else if (!is_hex)
                    begin
                        error <= 1'b1;
                        state <= hex_loader_pkg::parser_skip;
                    end
                default:
                    if (is_term)
                        state <= hex_loader_pkg::parser_idle;
                endcase
            end
            else if (busy)
            begin
                if (idle_timer == w_timer'(timeout_cycles - 1))
                begin
                    error      <= 1'b1;
                    state      <= hex_loader_pkg::parser_idle;
                    idle_timer <= '0;
                end
                else
                    idle_timer <= idle_timer + 1'b1;
            end
        end

    // field shifters
    always_ff @(posedge clk)
        if (in_valid && is_hex)
            case (state)
            hex_loader_pkg::parser_idle:    address <= {28'b0, nibble};
            hex_loader_pkg::parser_address: address <= {address[27:0], nibble};
            hex_loader_pkg::parser_gap:     data    <= {28'b0, nibble};
            hex_loader_pkg::parser_data:    data    <= {data[27:0], nibble};
            default:                        ;
            endcase

    assign busy = (state == hex_loader_pkg::parser_address)
               || (state == hex_loader_pkg::parser_gap)
               || (state == hex_loader_pkg::parser_data);

    assign write = '{valid: write_valid, address: address, data: data};

endmodule

/* verilog/seven_segment_display.sv */
`timescale 1ns/100ps

module seven_segment_display
#(
    parameter w_digit        = 4,
    parameter refresh_cycles = 4
)
(
    input                            clk,
    input                            rst,
    input        [w_digit * 4 - 1:0] number,
    output logic [7:0]               abcdefgh,
    output logic [w_digit - 1:0]     digit
);

    localparam w_refresh = $clog2(refresh_cycles + 1);
    localparam w_index   = (w_digit > 1) ? $clog2(w_digit) : 1;

    logic [w_refresh - 1:0] refresh_cnt;
    logic [w_index - 1:0]   index;
    logic [3:0]             nibble;
    logic [7:0]             glyph;

    // scan position
    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            refresh_cnt <= '0;
            index       <= '0;
        end
        else if (refresh_cnt == w_refresh'(refresh_cycles - 1))
        begin
            refresh_cnt <= '0;
            index       <= (index == w_index'(w_digit - 1)) ? '0 : index + 1'b1;
        end
        else
            refresh_cnt <= refresh_cnt + 1'b1;

    assign nibble = number[index * 4 +: 4];

    // active high abcdefg, dot in bit 0
    always_comb
        case (nibble)
        4'h0: glyph = 8'b1111_1100;
        4'h1: glyph = 8'b0110_0000;
        4'h2: glyph = 8'b1101_1010;
        4'h3: glyph = 8'b1111_0010;
        4'h4: glyph = 8'b0110_0110;
        4'h5: glyph = 8'b1011_0110;
        4'h6: glyph = 8'b1011_1110;
        4'h7: glyph = 8'b1110_0000;
        4'h8: glyph = 8'b1111_1110;
        4'h9: glyph = 8'b1111_0110;
        4'ha: glyph = 8'b1110_1110;
        4'hb: glyph = 8'b0011_1110;
        4'hc: glyph = 8'b1001_1100;
        4'hd: glyph = 8'b0111_1010;
        4'he: glyph = 8'b1001_1110;
        default: glyph = 8'b1000_1110;
        endcase

    // segments and select leave together, all digits dark in reset
    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            abcdefgh <= '1;
            digit    <= '1;
        end
        else
        begin
            abcdefgh <= ~glyph;
            digit    <= ~(w_digit'(1) << index);
        end

endmodule

/* verilog/uart_receiver.sv */
`timescale 1ns/100ps

module uart_receiver
#(
    parameter clks_per_bit = 8
)
(
    input                         clk,
    input                         rst,
    input                         rx,
    output logic                  byte_valid,
    output hex_loader_pkg::byte_t byte_data
);

    localparam w_cnt        = $clog2(clks_per_bit * 10 + 1);
    // cycles from the rx edge until the idle check sees it
    localparam sync_latency = 3;
    localparam first_sample = (clks_per_bit + 1) / 2;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t             state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic [w_cnt - 1:0]    cnt;
    logic [w_cnt - 1:0]    sample_at;
    logic [2:0]            bit_idx;
    hex_loader_pkg::byte_t shift_reg;

    // line idles high
    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end

    // cnt counts cycles since the start edge, sample_at is one short of the next centre
    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            state      <= rx_idle;
            cnt        <= '0;
            sample_at  <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end
        else
        begin
            byte_valid <= 1'b0;
            cnt        <= cnt + 1'b1;
            case (state)
            rx_idle:
                if (!rx_sync)
                begin
                    state     <= rx_start;
                    cnt       <= w_cnt'(sync_latency);
                    sample_at <= w_cnt'(first_sample - 1);
                end
            rx_start:
                if (cnt == sample_at)
                begin
                    // a glitch, not a start bit
                    if (rx_sync)
                        state <= rx_idle;
                    else
                        state <= rx_data;
                    sample_at <= sample_at + w_cnt'(clks_per_bit);
                    bit_idx   <= '0;
                end
            rx_data:
                if (cnt == sample_at)
                begin
                    shift_reg <= {rx_sync, shift_reg[7:1]};
                    sample_at <= sample_at + w_cnt'(clks_per_bit);
                    bit_idx   <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7)
                        state <= rx_stop;
                end
            rx_stop:
                if (cnt == sample_at)
                begin
                    // bad stop bit drops the byte
                    byte_valid <= rx_sync;
                    state      <= rx_idle;
                end
            default:
                state <= rx_idle;
            endcase
        end

    assign byte_data = shift_reg;

endmodule

/* verilog/word_monitor.sv */
`timescale 1ns/100ps

module word_monitor
#(
    parameter w_digit = 4
)
(
    input                              clk,
    input                              rst,
    input                              byte_valid,
    input  hex_loader_pkg::byte_t      byte_data,
    input  hex_loader_pkg::hex_write_t write,
    input        [3:0]                 key,
    output logic [w_digit * 4 - 1:0]   number
);

    localparam w_number = w_digit * 4;

    hex_loader_pkg::word_t last_bytes;
    // only the low half of the address is ever shown
    logic [15:0]           last_address;
    hex_loader_pkg::word_t last_word;
    logic [15:0]           slice;

    // newest byte in the low end
    always_ff @(posedge clk or posedge rst)
        if (rst)
            last_bytes <= '0;
        else if (byte_valid)
            last_bytes <= {last_bytes[23:0], byte_data};

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            last_address <= '0;
            last_word    <= '0;
        end
        else if (write.valid)
        begin
            last_address <= write.address[15:0];
            last_word    <= write.data;
        end

    // keys are active low, one pressed key picks a slice
    always_comb
        case (key)
        4'b0111: slice = last_bytes[31:16];
        4'b1011: slice = last_word[31:16];
        4'b1101: slice = last_word[15:0];
        4'b1110: slice = last_address;
        default: slice = last_bytes[15:0];
        endcase

    assign number = w_number'(slice);

endmodule
